/* vlog.f */
verilog/axi_bridge_pkg.sv
verilog/axi_read_engine.sv
verilog/axi_write_engine.sv
verilog/cache_axi_bridge.sv
dv/tb_clkgen.sv
dv/cache_axi_bridge_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the bridge testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module cache_axi_bridge_tb \
    -f vlog.f \
    -o cache_axi_bridge_sim

./obj_dir/cache_axi_bridge_sim | tee "$LOG"

if grep -q 'All tests passed!' "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* dv/cache_axi_bridge_tb.sv */
module cache_axi_bridge_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import axi_bridge_pkg::*;

    logic aclk;
    logic rst_n;

    // requester inputs
    logic       inst_rd_req  = 1'b0;
    addr_t      inst_rd_addr = '0;
    logic       data_rd_req  = 1'b0;
    req_kind_e  data_rd_type = KIND_WORD;
    addr_t      data_rd_addr = '0;
    logic [2:0] data_rd_size = SIZE_WORD;
    logic       wr_req       = 1'b0;
    req_kind_e  wr_type      = KIND_WORD;
    addr_t      wr_addr      = '0;
    strb_t      wr_wstrb     = '0;
    data_line_t wr_data      = '0;

    // requester outputs
    logic       inst_rd_rdy, inst_ret_valid, inst_ret_half;
    inst_line_t inst_ret_data;
    logic       data_rd_rdy, data_ret_valid;
    data_line_t data_ret_data;
    logic       wr_rdy, wr_ok;

    // AXI master outputs
    axi_id_t    arid, awid, wid;
    addr_t      araddr, awaddr;
    axi_len_t   arlen, awlen;
    logic [2:0] arsize, awsize, arprot, awprot;
    logic [1:0] arburst, arlock, awburst, awlock;
    logic [3:0] arcache, awcache;
    logic       arvalid, rready, awvalid, wvalid, wlast, bready;
    word_t      wdata;
    strb_t      wstrb;

    // slave model outputs where ids and responses stay at zero
    logic       arready = 1'b0;
    logic       rvalid  = 1'b0;
    logic       rlast   = 1'b0;
    word_t      rdata   = '0;
    logic       awready = 1'b0;
    logic       wready  = 1'b0;
    logic       bvalid  = 1'b0;
    axi_id_t    rid     = '0;
    axi_id_t    bid     = '0;
    logic [1:0] rresp   = '0;
    logic [1:0] bresp   = '0;

    word_t      mem [0:1023];
    logic       stall_en = 1'b0;
    integer     seed     = 32'hb1ba_0428;
    addr_t      rd_ptr   = '0;
    logic [8:0] rd_beats = '0;
    addr_t      wr_ptr   = '0;
    logic [1:0] wr_phase = 2'd0;

    // address phases seen on the bus
    addr_t      ar_addr_q [$];
    axi_len_t   ar_len_q [$];
    axi_id_t    ar_id_q [$];
    axi_len_t   aw_len_q [$];
    int         ar_base  = 0;
    int         aw_base  = 0;

    int errors   = 0;
    int err_base = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int cycles   = 0;

    tb_clkgen u_clkgen (
        .aclk  (aclk),
        .rst_n (rst_n)
    );

    cache_axi_bridge i_dut (.*);

    // roughly one cycle in four held off when stalls are on
    function automatic logic draw_stall();
        logic [31:0] r;
        r = $random(seed);
        return stall_en && (r[1:0] == 2'b00);
    endfunction

    // read slave serves one burst at a time
    always @(posedge aclk) begin
        if (!rst_n) begin
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rlast    <= 1'b0;
            rd_beats <= '0;
        end else begin
            arready <= (rd_beats == 9'd0) && !rvalid && !draw_stall();
            if (arvalid && arready) begin
                arready  <= 1'b0;
                rd_ptr   <= araddr;
                rd_beats <= {1'b0, arlen} + 9'd1;
            end else if (!rvalid || rready) begin
                if (rd_beats != 9'd0 && !draw_stall()) begin
                    rvalid   <= 1'b1;
                    rdata    <= mem[rd_ptr[11:2]];
                    rlast    <= (rd_beats == 9'd1);
                    rd_ptr   <= rd_ptr + 32'd4;
                    rd_beats <= rd_beats - 9'd1;
                end else begin
                    rvalid <= 1'b0;
                end
            end
        end
    end

    // write slave steps through address, data and response
    always @(posedge aclk) begin
        if (!rst_n) begin
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            wr_phase <= 2'd0;
            // every word starts as its byte address xor 5a5a0000
            for (int i = 0; i < 1024; i++) begin
                mem[i] <= word_t'(i * 4) ^ 32'h5a5a_0000;
            end
        end else begin
            case (wr_phase)
                2'd0: begin
                    awready <= !draw_stall();
                    if (awvalid && awready) begin
                        awready  <= 1'b0;
                        wr_ptr   <= awaddr;
                        wr_phase <= 2'd1;
                    end
                end
                2'd1: begin
                    wready <= !draw_stall();
                    if (wvalid && wready) begin
                        for (int b = 0; b < 4; b++) begin
                            if (wstrb[b]) begin
                                mem[wr_ptr[11:2]][8*b +: 8] <= wdata[8*b +: 8];
                            end
                        end
                        wr_ptr <= wr_ptr + 32'd4;
                        if (wlast) begin
                            wready   <= 1'b0;
                            bvalid   <= 1'b1;
                            wr_phase <= 2'd2;
                        end
                    end
                end
                default: begin
                    if (bvalid && bready) begin
                        bvalid   <= 1'b0;
                        wr_phase <= 2'd0;
                    end
                end
            endcase
        end
    end

    // fixed AXI fields checked at every handshake
    always @(posedge aclk) begin
        if (arvalid && arready) begin
            ar_addr_q.push_back(araddr);
            ar_len_q.push_back(arlen);
            ar_id_q.push_back(arid);
            compare_word(word_t'({arsize, arburst, arlock, arcache, arprot}),
                         word_t'({SIZE_WORD, BURST_INCR, 2'd0, 4'd0, 3'd0}),
                         "arsize, arburst, arlock, arcache and arprot");
        end
        if (awvalid && awready) begin
            aw_len_q.push_back(awlen);
            compare_word(word_t'({awid, awsize, awburst, awlock, awcache, awprot}),
                         word_t'({ID_DATA, SIZE_WORD, BURST_INCR, 2'd0, 4'd0, 3'd0}),
                         "awid, awsize, awburst, awlock, awcache and awprot");
        end
        if (wvalid && wready) begin
            compare_word(word_t'(wid), word_t'(ID_DATA), "wid");
        end
    end

    // nine tests of a few stalled bursts each stay far below this limit
    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles == 4000) begin
            $display("timeout: no result after 4000 cycles, the DUT stopped responding");
            $display("Test failures found");
            $finish;
        end
    end

    function automatic word_t mem_rule(input addr_t a);
        return a ^ 32'h5a5a_0000;
    endfunction

    function automatic inst_line_t expect_line(input addr_t a, input int words);
        inst_line_t line;
        line = '0;
        for (int i = 0; i < words; i++) begin
            line[WORD_BITS*i +: WORD_BITS] = mem_rule(a + addr_t'(4 * i));
        end
        return line;
    endfunction

    task automatic report_problem(input string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic compare_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_data_line(input data_line_t got, input data_line_t exp,
                                     input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_inst_line(input inst_line_t got, input inst_line_t exp,
                                     input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_len(input axi_len_t got, input axi_len_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_id(input axi_id_t got, input axi_id_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == err_base) begin
            pass_cnt++;
            $display("[%0t] %s: pass", $time, name);
        end else begin
            fail_cnt++;
            $display("[%0t] %s: fail, %0d errors", $time, name, errors - err_base);
        end
        err_base = errors;
    endtask

    // issues the wanted reads together and waits for each ret_valid
    task automatic run_reads(input logic want_inst, input addr_t ia, input logic want_data,
                             input req_kind_e kind, input addr_t da,
                             output inst_line_t iline, output data_line_t dline,
                             output data_line_t half_line);
        logic inst_done;
        logic data_done;
        logic half_seen;
        inst_done = !want_inst;
        data_done = !want_data;
        half_seen = 1'b0;
        ar_base   = ar_addr_q.size();
        @(posedge aclk);
        inst_rd_req  <= want_inst;
        inst_rd_addr <= ia;
        data_rd_req  <= want_data;
        data_rd_type <= kind;
        data_rd_addr <= da;
        while (!(inst_done && data_done)) begin
            @(posedge aclk);
            if (data_rd_req && data_rd_rdy) begin
                data_rd_req <= 1'b0;
            end
            if (inst_rd_req && inst_rd_rdy) begin
                inst_rd_req <= 1'b0;
            end
            if (inst_ret_half) begin
                half_seen = 1'b1;
                half_line = data_line_t'(inst_ret_data);
            end
            if (data_ret_valid) begin
                data_done = 1'b1;
                dline     = data_ret_data;
            end
            if (inst_ret_valid) begin
                if (!data_done) begin
                    report_problem("instruction line returned before the data read");
                end
                if (!half_seen) begin
                    report_problem("inst_ret_half did not pulse before inst_ret_valid");
                end
                inst_done = 1'b1;
                iline     = inst_ret_data;
            end
        end
    endtask

    task automatic run_write(input req_kind_e kind, input addr_t a, input strb_t strb,
                             input data_line_t d);
        int oks;
        oks     = 0;
        aw_base = aw_len_q.size();
        @(posedge aclk);
        wr_req   <= 1'b1;
        wr_type  <= kind;
        wr_addr  <= a;
        wr_wstrb <= strb;
        wr_data  <= d;
        while (oks == 0) begin
            @(posedge aclk);
            if (wr_req && wr_rdy) begin
                wr_req <= 1'b0;
            end
            if (wr_ok) begin
                oks++;
            end
        end
        // a second pulse would show up within a few cycles
        repeat (4) begin
            @(posedge aclk);
            if (wr_ok) begin
                oks++;
            end
        end
        if (oks != 1) begin
            report_problem("wr_ok pulsed more than once for one write");
        end
    endtask

    task automatic reset_test();
        compare_word({20'd0, arvalid, rready, awvalid, wvalid, bready, inst_ret_valid,
                      inst_ret_half, data_ret_valid, wr_ok, inst_rd_rdy, data_rd_rdy,
                      wr_rdy}, 32'h0000_0007, "strobes and rdy after reset");
        finish_test("reset state");
    endtask

    task automatic inst_read_test(input addr_t a);
        inst_line_t iline;
        data_line_t dline;
        data_line_t half;
        inst_line_t exp;
        exp = expect_line(a, INST_LINE_WORDS);
        run_reads(1'b1, a, 1'b0, KIND_LINE, '0, iline, dline, half);
        compare_len(ar_len_q[ar_base], 8'd7, "arlen");
        compare_id(ar_id_q[ar_base], ID_INST, "arid");
        compare_data_line(half, data_line_t'(exp), "words 0 to 3 at inst_ret_half");
        compare_inst_line(iline, exp, "instruction line");
        finish_test("instruction line read");
    endtask

    task automatic data_read_test(input addr_t la, input addr_t wa);
        inst_line_t iline;
        data_line_t dline;
        data_line_t half;
        run_reads(1'b0, '0, 1'b1, KIND_LINE, la, iline, dline, half);
        compare_len(ar_len_q[ar_base], 8'd3, "arlen of line read");
        compare_id(ar_id_q[ar_base], ID_DATA, "arid of line read");
        compare_data_line(dline, data_line_t'(expect_line(la, DATA_LINE_WORDS)), "data line");
        run_reads(1'b0, '0, 1'b1, KIND_WORD, wa, iline, dline, half);
        compare_len(ar_len_q[ar_base], 8'd0, "arlen of word read");
        compare_word(dline[31:0], mem_rule(wa), "data word");
        finish_test("data line and word reads");
    endtask

    task automatic arbitration_test(input addr_t ia, input addr_t da);
        inst_line_t iline;
        data_line_t dline;
        data_line_t half;
        run_reads(1'b1, ia, 1'b1, KIND_LINE, da, iline, dline, half);
        compare_word(ar_addr_q[ar_base], da, "first araddr");
        compare_data_line(dline, data_line_t'(expect_line(da, DATA_LINE_WORDS)), "data line");
        compare_inst_line(iline, expect_line(ia, INST_LINE_WORDS), "instruction line");
        finish_test("read arbitration");
    endtask

    task automatic write_test(input addr_t wa, input addr_t la);
        inst_line_t iline;
        data_line_t dline;
        data_line_t half;
        data_line_t line;
        word_t      merged;
        run_write(KIND_WORD, wa, 4'b0101, {96'd0, 32'hcafe_f00d});
        compare_len(aw_len_q[aw_base], 8'd0, "awlen of word write");
        // bytes 0 and 2 come from the write and bytes 1 and 3 stay
        merged = (mem_rule(wa) & 32'hff00_ff00) | (32'hcafe_f00d & 32'h00ff_00ff);
        run_reads(1'b0, '0, 1'b1, KIND_WORD, wa, iline, dline, half);
        compare_word(dline[31:0], merged, "merged word");
        line = ~data_line_t'(expect_line(la, DATA_LINE_WORDS));
        run_write(KIND_LINE, la, 4'b0000, line);
        compare_len(aw_len_q[aw_base], 8'd3, "awlen of line write");
        run_reads(1'b0, '0, 1'b1, KIND_LINE, la, iline, dline, half);
        compare_data_line(dline, line, "written line");
        finish_test("word and line writes");
    endtask

    initial begin
        addr_t base;
        wait (rst_n === 1'b1);
        @(posedge aclk);
        reset_test();
        // second pass repeats everything against a stalling slave on fresh addresses
        for (int pass = 0; pass < 2; pass++) begin
            stall_en <= (pass == 1);
            base = (pass == 0) ? 32'h0000_0000 : 32'h0000_0800;
            inst_read_test(base + 32'h040);
            data_read_test(base + 32'h090, base + 32'h0a4);
            arbitration_test(base + 32'h100, base + 32'h0d0);
            write_test(base + 32'h200, base + 32'h240);
        end
        $display("tests finished: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* dv/tb_clkgen.sv */
module tb_clkgen (
    output logic aclk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // 100 ns period
    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    // reset held for the first 10 rising edges
    initial begin
        rst_n <= 1'b0;
        repeat (10) @(posedge aclk);
        rst_n <= 1'b1;
    end

endmodule

/* verilog/cache_axi_bridge.sv */
module cache_axi_bridge (
    input  logic                       aclk,
    input  logic                       rst_n,
    // instruction cache reads
    input  logic                       inst_rd_req,
    input  axi_bridge_pkg::addr_t      inst_rd_addr,
    output logic                       inst_rd_rdy,
    output logic                       inst_ret_valid,
    output logic                       inst_ret_half,
    output axi_bridge_pkg::inst_line_t inst_ret_data,
    // data cache reads
    input  logic                       data_rd_req,
    input  axi_bridge_pkg::req_kind_e  data_rd_type,
    input  axi_bridge_pkg::addr_t      data_rd_addr,
    input  logic [2:0]                 data_rd_size,
    output logic                       data_rd_rdy,
    output logic                       data_ret_valid,
    output axi_bridge_pkg::data_line_t data_ret_data,
    // data cache writes
    input  logic                       wr_req,
    input  axi_bridge_pkg::req_kind_e  wr_type,
    input  axi_bridge_pkg::addr_t      wr_addr,
    input  axi_bridge_pkg::strb_t      wr_wstrb,
    input  axi_bridge_pkg::data_line_t wr_data,
    output logic                       wr_rdy,
    output logic                       wr_ok,
    // AXI master port
    output axi_bridge_pkg::axi_id_t    arid,
    output axi_bridge_pkg::addr_t      araddr,
    output axi_bridge_pkg::axi_len_t   arlen,
    output logic [2:0]                 arsize,
    output logic [1:0]                 arburst,
    output logic [1:0]                 arlock,
    output logic [3:0]                 arcache,
    output logic [2:0]                 arprot,
    output logic                       arvalid,
    input  logic                       arready,
    input  axi_bridge_pkg::axi_id_t    rid,
    input  axi_bridge_pkg::word_t      rdata,
    input  logic [1:0]                 rresp,
    input  logic                       rlast,
    input  logic                       rvalid,
    output logic                       rready,
    output axi_bridge_pkg::axi_id_t    awid,
    output axi_bridge_pkg::addr_t      awaddr,
    output axi_bridge_pkg::axi_len_t   awlen,
    output logic [2:0]                 awsize,
    output logic [1:0]                 awburst,
    output logic [1:0]                 awlock,
    output logic [3:0]                 awcache,
    output logic [2:0]                 awprot,
    output logic                       awvalid,
    input  logic                       awready,
    output axi_bridge_pkg::axi_id_t    wid,
    output axi_bridge_pkg::word_t      wdata,
    output axi_bridge_pkg::strb_t      wstrb,
    output logic                       wlast,
    output logic                       wvalid,
    input  logic                       wready,
    input  axi_bridge_pkg::axi_id_t    bid,
    input  logic [1:0]                 bresp,
    input  logic                       bvalid,
    output logic                       bready
);
    import axi_bridge_pkg::*;

    // rid, rresp, bid and bresp are not checked,
    // one read and one write in flight so ids never need matching

    assign arburst = BURST_INCR;
    assign arlock  = '0;
    assign arcache = '0;
    assign arprot  = '0;

    // writes always come from the data cache in full words
    assign awid    = ID_DATA;
    assign wid     = ID_DATA;
    assign awsize  = SIZE_WORD;
    assign awburst = BURST_INCR;
    assign awlock  = '0;
    assign awcache = '0;
    assign awprot  = '0;

    axi_read_engine u_read (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .inst_rd_req    (inst_rd_req),
        .inst_rd_addr   (inst_rd_addr),
        .inst_rd_rdy    (inst_rd_rdy),
        .inst_ret_valid (inst_ret_valid),
        .inst_ret_half  (inst_ret_half),
        .inst_ret_data  (inst_ret_data),
        .data_rd_req    (data_rd_req),
        .data_rd_type   (data_rd_type),
        .data_rd_addr   (data_rd_addr),
        .data_rd_size   (data_rd_size),
        .data_rd_rdy    (data_rd_rdy),
        .data_ret_valid (data_ret_valid),
        .data_ret_data  (data_ret_data),
        .arid           (arid),
        .araddr         (araddr),
        .arlen          (arlen),
        .arsize         (arsize),
        .arvalid        (arvalid),
        .arready        (arready),
        .rdata          (rdata),
        .rlast          (rlast),
        .rvalid         (rvalid),
        .rready         (rready)
    );

    axi_write_engine u_write (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .wr_req   (wr_req),
        .wr_type  (wr_type),
        .wr_addr  (wr_addr),
        .wr_wstrb (wr_wstrb),
        .wr_data  (wr_data),
        .wr_rdy   (wr_rdy),
        .wr_ok    (wr_ok),
        .awaddr   (awaddr),
        .awlen    (awlen),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wlast    (wlast),
        .wvalid   (wvalid),
        .wready   (wready),
        .bvalid   (bvalid),
        .bready   (bready)
    );

endmodule

/* verilog/axi_write_engine.sv */
module axi_write_engine (
    input  logic                       aclk,
    input  logic                       rst_n,
    // data cache writeback side
    input  logic                       wr_req,
    input  axi_bridge_pkg::req_kind_e  wr_type,
    input  axi_bridge_pkg::addr_t      wr_addr,
    input  axi_bridge_pkg::strb_t      wr_wstrb,
    input  axi_bridge_pkg::data_line_t wr_data,
    output logic                       wr_rdy,
    output logic                       wr_ok,
    // AXI write address
    output axi_bridge_pkg::addr_t      awaddr,
    output axi_bridge_pkg::axi_len_t   awlen,
    output logic                       awvalid,
    input  logic                       awready,
    // AXI write data
    output axi_bridge_pkg::word_t      wdata,
    output axi_bridge_pkg::strb_t      wstrb,
    output logic                       wlast,
    output logic                       wvalid,
    input  logic                       wready,
    // AXI write response
    input  logic                       bvalid,
    output logic                       bready
);
    import axi_bridge_pkg::*;

    write_state_e state;
    req_kind_e    kind;
    strb_t        word_strb;
    data_line_t   line;
    logic [1:0]   beat_cnt;
    logic         take;
    logic         beat_fire;

    assign wr_rdy = (state == WR_IDLE);
    assign take   = wr_req && wr_rdy;

    assign awvalid   = (state == WR_ADDR);
    assign wvalid    = (state == WR_DATA);
    assign bready    = (state == WR_RESP);
    assign beat_fire = wvalid && wready;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (take) begin
                        state <= WR_ADDR;
                    end
                end
                WR_ADDR: begin
                    if (awready) begin
                        state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (beat_fire && wlast) begin
                        state <= WR_RESP;
                    end
                end
                default: begin
                    if (bvalid) begin
                        state <= WR_IDLE;
                    end
                end
            endcase
        end
    end

    // request held for the whole transaction
    always_ff @(posedge aclk) begin
        if (take) begin
            awaddr    <= wr_addr;
            kind      <= wr_type;
            word_strb <= wr_wstrb;
            line      <= wr_data;
            if (wr_type == KIND_LINE) begin
                awlen <= axi_len_t'(DATA_LINE_WORDS - 1);
            end else begin
                awlen <= '0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            wr_ok    <= 1'b0;
        end else begin
            if (take) begin
                beat_cnt <= '0;
            end else if (beat_fire) begin
                beat_cnt <= beat_cnt + 2'd1;
            end
            wr_ok <= bvalid && bready;
        end
    end

    // low word first, the counter also marks the last beat
    assign wdata = line[WORD_BITS*beat_cnt +: WORD_BITS];
    assign wlast = (beat_cnt == awlen[1:0]);
    // full lines write every byte
    assign wstrb = (kind == KIND_LINE) ? 4'hf : word_strb;

endmodule

/* verilog/axi_read_engine.sv */
module axi_read_engine (
    input  logic                       aclk,
    input  logic                       rst_n,
    // instruction cache side
    input  logic                       inst_rd_req,
    input  axi_bridge_pkg::addr_t      inst_rd_addr,
    output logic                       inst_rd_rdy,
    output logic                       inst_ret_valid,
    output logic                       inst_ret_half,
    output axi_bridge_pkg::inst_line_t inst_ret_data,
    // data cache side
    input  logic                       data_rd_req,
    input  axi_bridge_pkg::req_kind_e  data_rd_type,
    input  axi_bridge_pkg::addr_t      data_rd_addr,
    input  logic [2:0]                 data_rd_size,
    output logic                       data_rd_rdy,
    output logic                       data_ret_valid,
    output axi_bridge_pkg::data_line_t data_ret_data,
    // AXI read address
    output axi_bridge_pkg::axi_id_t    arid,
    output axi_bridge_pkg::addr_t      araddr,
    output axi_bridge_pkg::axi_len_t   arlen,
    output logic [2:0]                 arsize,
    output logic                       arvalid,
    input  logic                       arready,
    // AXI read data
    input  axi_bridge_pkg::word_t      rdata,
    input  logic                       rlast,
    input  logic                       rvalid,
    output logic                       rready
);
    import axi_bridge_pkg::*;

    read_state_e state;
    logic        rd_idle;
    logic        take_data;
    logic        take_inst;
    logic        beat_fire;
    logic        cur_inst;
    logic [2:0]  beat_cnt;
    inst_line_t  line_buf;

    assign rd_idle = (state == RD_IDLE);

    // data side has priority, so the instruction side
    // only sees rdy when no data read competes
    assign data_rd_rdy = rd_idle;
    assign inst_rd_rdy = rd_idle && !data_rd_req;

    assign take_data = data_rd_req && data_rd_rdy;
    assign take_inst = inst_rd_req && inst_rd_rdy;

    assign arvalid   = (state == RD_ADDR);
    assign rready    = (state == RD_DATA);
    assign beat_fire = rvalid && rready;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (take_data || take_inst) begin
                        state <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (arready) begin
                        state <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (beat_fire && rlast) begin
                        state <= RD_RETURN;
                    end
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    // burst fields, stable until the next accept
    always_ff @(posedge aclk) begin
        if (take_data) begin
            cur_inst <= 1'b0;
            araddr   <= data_rd_addr;
            arid     <= ID_DATA;
            if (data_rd_type == KIND_LINE) begin
                arlen  <= axi_len_t'(DATA_LINE_WORDS - 1);
                arsize <= SIZE_WORD;
            end else begin
                // narrow uncached reads keep their own size
                arlen  <= '0;
                arsize <= data_rd_size;
            end
        end else if (take_inst) begin
            cur_inst <= 1'b1;
            araddr   <= inst_rd_addr;
            arid     <= ID_INST;
            arlen    <= axi_len_t'(INST_LINE_WORDS - 1);
            arsize   <= SIZE_WORD;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            beat_cnt      <= '0;
            inst_ret_half <= 1'b0;
        end else begin
            if (take_data || take_inst) begin
                beat_cnt <= '0;
            end else if (beat_fire) begin
                beat_cnt <= beat_cnt + 3'd1;
            end
            // fourth beat in, first half of the line usable
            inst_ret_half <= beat_fire && cur_inst && (beat_cnt == 3'd3);
        end
    end

    // beats land in place, word 0 at the bottom
    always_ff @(posedge aclk) begin
        if (beat_fire) begin
            line_buf[WORD_BITS*beat_cnt +: WORD_BITS] <= rdata;
        end
    end

    assign inst_ret_valid = (state == RD_RETURN) && cur_inst;
    assign data_ret_valid = (state == RD_RETURN) && !cur_inst;
    assign inst_ret_data  = line_buf;
    assign data_ret_data  = line_buf[DATA_LINE_WORDS*WORD_BITS-1:0];

endmodule

/* verilog/axi_bridge_pkg.sv */
package axi_bridge_pkg;

    // bus and line geometry
    localparam int WORD_BITS       = 32;
    localparam int INST_LINE_WORDS = 8;
    localparam int DATA_LINE_WORDS = 4;

    typedef logic [WORD_BITS-1:0]                   word_t;
    typedef logic [31:0]                            addr_t;
    typedef logic [3:0]                             strb_t;
    typedef logic [INST_LINE_WORDS*WORD_BITS-1:0]   inst_line_t;
    typedef logic [DATA_LINE_WORDS*WORD_BITS-1:0]   data_line_t;

    typedef logic [3:0] axi_id_t;
    typedef logic [7:0] axi_len_t;

    // ids on the master port
    localparam axi_id_t ID_INST = 4'd0;
    localparam axi_id_t ID_DATA = 4'd1;

    // fixed AXI field encodings
    localparam logic [1:0] BURST_INCR = 2'd1;
    // 4 bytes per beat
    localparam logic [2:0] SIZE_WORD  = 3'd2;

    typedef enum logic [1:0] {
        RD_IDLE   = 2'd0,
        RD_ADDR   = 2'd1,
        RD_DATA   = 2'd2,
        RD_RETURN = 2'd3
    } read_state_e;

    typedef enum logic [1:0] {
        WR_IDLE = 2'd0,
        WR_ADDR = 2'd1,
        WR_DATA = 2'd2,
        WR_RESP = 2'd3
    } write_state_e;

    // single word or full cache line
    typedef enum logic {
        KIND_WORD = 1'b0,
        KIND_LINE = 1'b1
    } req_kind_e;

endpackage
